/* src.f */
hw/zle_pkg.sv
hw/zle_apb_pkg.sv
hw/zle_regs.sv
hw/zle_fsm.sv
hw/zle_datapath.sv
hw/zle_top.sv
verif/zle_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the zle testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns -f src.f --top-module zle_tb -o zle_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/zle_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1

/* verif/zle_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zle testbench
// table driven stream tests, APB setup, random sink stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module zle_tb;

   import zle_apb_pkg::*;

   localparam int DATA_W      = 16;
   localparam int CNT_W       = 4;
   localparam int NROWS       = 7;
   localparam int NWORDS      = 79;
   localparam int APB_CYC_ROW = 24;  // five accesses and the drain
   localparam logic [DATA_W-1:0] ZW = '0;

   logic              clock;
   logic              reset;
   logic              i_in_valid;
   logic [DATA_W-1:0] i_in_data;
   logic              o_in_busy;
   logic              o_out_valid;
   logic [DATA_W-1:0] o_out_data;
   logic              o_out_run;
   logic              i_out_busy = 1'b0;
   logic              i_psel;
   logic              i_penable;
   logic              i_pwrite;
   logic [APB_AW-1:0] i_paddr;
   logic [APB_DW-1:0] i_pwdata;
   logic [APB_DW-1:0] o_prdata;
   logic              o_pready;

   // limit written, word count and sink busy percent of each row
   int row_limit [NROWS] = '{15, 15, 3, 1, 0, 4, 15};
   int row_len   [NROWS] = '{5, 7, 12, 6, 3, 25, 21};
   int row_busy  [NROWS] = '{0, 0, 0, 25, 0, 50, 40};
   logic [DATA_W-1:0] word_tab [NWORDS] = '{
      16'h1234, 16'habcd, 16'h0001, 16'hffff, 16'h8000,
      16'h0011, ZW, ZW, ZW, 16'h0022, ZW, 16'h0033,
      ZW, ZW, ZW, ZW, ZW, ZW, ZW, 16'h0044, ZW, ZW, ZW, 16'h0055,
      ZW, ZW, ZW, 16'h0066, ZW, 16'h0077,
      ZW, ZW, 16'h0088,
      ZW, ZW, ZW, ZW, ZW, ZW, ZW, ZW, ZW, ZW, 16'h0099, 16'h00aa, ZW, 16'h00bb,
      ZW, ZW, ZW, ZW, 16'h00cc, ZW, ZW, ZW, ZW, ZW, 16'h00dd,
      ZW, ZW, ZW, ZW, ZW, ZW, ZW, ZW, ZW, ZW,
      ZW, ZW, ZW, ZW, ZW, ZW, ZW, ZW, ZW, ZW, 16'h00ee
   };

   logic [DATA_W:0] got_q [$];  // {run, data} seen at the output
   logic [DATA_W:0] exp_q [$];
   logic [31:0]     lcg_state = 32'h240d;
   int              busy_pct = 0;
   int              exp_runs;
   int              errors;
   int              mon_errors = 0;
   int              cycle_count = 0;
   int              max_cycles;

   zle_top #(
      .DATA_W (DATA_W),
      .CNT_W  (CNT_W)
   ) uut (
      .clock       (clock),
      .reset       (reset),
      .i_in_valid  (i_in_valid),
      .i_in_data   (i_in_data),
      .o_in_busy   (o_in_busy),
      .o_out_valid (o_out_valid),
      .o_out_data  (o_out_data),
      .o_out_run   (o_out_run),
      .i_out_busy  (i_out_busy),
      .i_psel      (i_psel),
      .i_penable   (i_penable),
      .i_pwrite    (i_pwrite),
      .i_paddr     (i_paddr),
      .i_pwdata    (i_pwdata),
      .o_prdata    (o_prdata),
      .o_pready    (o_pready)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   function automatic int random_percent();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return int'(lcg_state[23:16]) % 100;
   endfunction

   always @(negedge clock) begin
      i_out_busy = (random_percent() < busy_pct);  // sink stalls
   end

   always @(posedge clock) begin
      if (reset && o_out_valid) begin
         got_q.push_back({o_out_run, o_out_data});
         assert (!i_out_busy) else begin
            mon_errors++;
            $display("Fail o_out_valid: got 0x1 expected 0x0 while i_out_busy high");
         end
      end
   end

   always @(posedge clock) begin
      cycle_count++;
      if (cycle_count > max_cycles) begin
         $display("timeout after %0d cycles with tokens still missing, errors %0d",
                  cycle_count, errors + mon_errors);
         $display("tests failed");
         $finish;
      end
   end

   task automatic expect_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got == exp) else begin
         errors++;
         $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
      @(negedge clock);
      i_psel    = 1'b1;
      i_pwrite  = 1'b1;
      i_paddr   = addr;
      i_pwdata  = data;
      @(negedge clock);
      i_penable = 1'b1;  // access phase
      @(posedge clock);
      expect_hex("o_pready", 32'(o_pready), 32'h1);
      @(negedge clock);
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
      @(negedge clock);
      i_psel    = 1'b1;
      i_pwrite  = 1'b0;
      i_paddr   = addr;
      @(negedge clock);
      i_penable = 1'b1;
      @(posedge clock);
      expect_hex("o_pready", 32'(o_pready), 32'h1);
      data = o_prdata;
      @(negedge clock);
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   task automatic push_word(input logic [DATA_W-1:0] w);
      @(negedge clock);
      i_in_valid = 1'b1;
      i_in_data  = w;
      @(posedge clock);
      while (o_in_busy) begin
         @(posedge clock);
      end
   endtask

   task automatic build_expected(input int base, input int len, input int lim);
      int run;
      int chunk;
      run      = 0;
      exp_runs = 0;
      exp_q.delete();
      for (int i = 0; i < len; i++) begin
         if (word_tab[base + i] == ZW) begin
            run++;
         end else begin
            // zeros so far go out in chunks of at most the limit
            while (run > 0) begin
               chunk = (run > lim) ? lim : run;
               exp_q.push_back({1'b1, DATA_W'(chunk)});
               exp_runs++;
               run -= chunk;
            end
            exp_q.push_back({1'b0, word_tab[base + i]});
         end
      end
   endtask

   task automatic run_row(input int r, input int base);
      int                lim;
      int                first;
      logic [APB_DW-1:0] rd;
      lim      = (row_limit[r] == 0) ? 1 : row_limit[r];  // zero is stored as one
      busy_pct = row_busy[r];
      apb_write(REG_LIMIT, APB_DW'(row_limit[r]));
      apb_read(REG_LIMIT, rd);
      expect_hex("REG_LIMIT", rd, APB_DW'(lim));
      apb_write(REG_RUNS, 32'h1);
      apb_read(REG_RUNS, rd);
      expect_hex("REG_RUNS", rd, 32'h0);
      build_expected(base, row_len[r], lim);
      first = got_q.size();
      for (int i = 0; i < row_len[r]; i++) begin
         push_word(word_tab[base + i]);
      end
      @(negedge clock);
      i_in_valid = 1'b0;
      while (got_q.size() - first < exp_q.size()) begin
         @(negedge clock);
      end
      repeat (4) @(negedge clock);  // a stray extra token would land here
      assert (got_q.size() - first == exp_q.size()) else begin
         errors++;
         $display("row %0d: %0d tokens received where %0d were expected",
                  r, got_q.size() - first, exp_q.size());
      end
      for (int i = 0; i < exp_q.size(); i++) begin
         expect_hex("o_out_run", 32'(got_q[first + i][DATA_W]), 32'(exp_q[i][DATA_W]));
         expect_hex("o_out_data", 32'(got_q[first + i][DATA_W-1:0]),
                    32'(exp_q[i][DATA_W-1:0]));
      end
      apb_read(REG_RUNS, rd);
      expect_hex("REG_RUNS", rd, APB_DW'(exp_runs));
   endtask

   initial begin
      int                base;
      logic [APB_DW-1:0] rd;
      reset      = 1'b0;
      i_in_valid = 1'b0;
      i_in_data  = '0;
      i_psel     = 1'b0;
      i_penable  = 1'b0;
      i_pwrite   = 1'b0;
      i_paddr    = '0;
      i_pwdata   = '0;
      errors     = 0;
      max_cycles = 16;  // reset and the first two reads
      for (int r = 0; r < NROWS; r++) begin
         max_cycles += 4 * row_len[r] + APB_CYC_ROW;
      end
      repeat (4) @(negedge clock);
      reset = 1'b1;
      @(negedge clock);
      expect_hex("o_out_valid", 32'(o_out_valid), 32'h0);
      expect_hex("o_in_busy", 32'(o_in_busy), 32'h1);
      apb_read(REG_LIMIT, rd);
      expect_hex("REG_LIMIT", rd, APB_DW'((1 << CNT_W) - 1));  // counter maximum
      apb_read(REG_RUNS, rd);
      expect_hex("REG_RUNS", rd, 32'h0);
      base = 0;
      for (int r = 0; r < NROWS; r++) begin
         run_row(r, base);
         base += row_len[r];
      end
      $display("errors: %0d in checks, %0d in output monitor", errors, mon_errors);
      if (errors + mon_errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hw/zle_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zle top
// zero run-length encoder with APB control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module zle_top #(
   parameter int DATA_W = zle_pkg::DATA_W_DEF,
   parameter int CNT_W  = zle_pkg::CNT_W_DEF
) (
   input  wire                              clock,
   input  wire                              reset,
   input  wire                              i_in_valid,
   input  wire [DATA_W-1:0]                 i_in_data,
   output logic                             o_in_busy,
   output logic                             o_out_valid,
   output logic [DATA_W-1:0]                o_out_data,
   output logic                             o_out_run,
   input  wire                              i_out_busy,
   input  wire                              i_psel,
   input  wire                              i_penable,
   input  wire                              i_pwrite,
   input  wire [zle_apb_pkg::APB_AW-1:0]    i_paddr,
   input  wire [zle_apb_pkg::APB_DW-1:0]    i_pwdata,
   output logic [zle_apb_pkg::APB_DW-1:0]   o_prdata,
   output logic                             o_pready
);

   import zle_pkg::*;

   sel_out_t          sel_out;
   sel_cnt_t          sel_cnt;
   sel_flag_t         sel_flag;
   logic              load;
   logic              flag;
   logic              run_sent;
   logic [CNT_W-1:0]  limit;

   zle_regs #(
      .CNT_W (CNT_W)
   ) u_regs (
      .clock      (clock),
      .reset      (reset),
      .i_psel     (i_psel),
      .i_penable  (i_penable),
      .i_pwrite   (i_pwrite),
      .i_paddr    (i_paddr),
      .i_pwdata   (i_pwdata),
      .i_run_sent (run_sent),
      .o_prdata   (o_prdata),
      .o_pready   (o_pready),
      .o_limit    (limit)
   );

   zle_fsm u_fsm (
      .clock       (clock),
      .reset       (reset),
      .i_in_valid  (i_in_valid),
      .o_in_busy   (o_in_busy),
      .o_out_valid (o_out_valid),
      .i_out_busy  (i_out_busy),
      .i_flag      (flag),
      .o_load      (load),
      .o_sel_out   (sel_out),
      .o_sel_cnt   (sel_cnt),
      .o_sel_flag  (sel_flag),
      .o_run_sent  (run_sent)
   );

   zle_datapath #(
      .DATA_W (DATA_W),
      .CNT_W  (CNT_W)
   ) u_datapath (
      .clock      (clock),
      .reset      (reset),
      .i_in_data  (i_in_data),
      .i_load     (load),
      .i_sel_out  (sel_out),
      .i_sel_cnt  (sel_cnt),
      .i_sel_flag (sel_flag),
      .i_limit    (limit),
      .o_out_data (o_out_data),
      .o_out_run  (o_out_run),
      .o_flag     (flag)
   );

endmodule

`default_nettype wire

/* hw/zle_datapath.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zle datapath
// held word, run counter, output mux and shared flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module zle_datapath #(
   parameter int DATA_W = zle_pkg::DATA_W_DEF,
   parameter int CNT_W  = zle_pkg::CNT_W_DEF
) (
   input  wire                         clock,
   input  wire                         reset,
   input  wire [DATA_W-1:0]            i_in_data,
   input  wire                         i_load,
   input  wire zle_pkg::sel_out_t      i_sel_out,
   input  wire zle_pkg::sel_cnt_t      i_sel_cnt,
   input  wire zle_pkg::sel_flag_t     i_sel_flag,
   input  wire [CNT_W-1:0]             i_limit,
   output logic [DATA_W-1:0]           o_out_data,
   output logic                        o_out_run,
   output logic                        o_flag
);

   import zle_pkg::*;

   logic [DATA_W-1:0] held_data;
   logic [CNT_W-1:0]  run_cnt;

   always_ff @(posedge clock) begin
      if (i_load) begin
         held_data <= i_in_data;  // last accepted word
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         run_cnt <= '0;
      end else begin
         case (i_sel_cnt)
            SEL_CNT_START, SEL_CNT_FULL: run_cnt <= CNT_W'(1);
            SEL_CNT_INC:                 run_cnt <= run_cnt + CNT_W'(1);
            default:                     run_cnt <= run_cnt;
         endcase
      end
   end

   assign o_out_run  = (i_sel_out == SEL_OUT_RUN);
   assign o_out_data = o_out_run ? {{(DATA_W-CNT_W){1'b0}}, run_cnt} : held_data;

   // one compare output shared between the two FSM tests
   assign o_flag = (i_sel_flag == SEL_FLAG_LIMIT) ? (run_cnt == i_limit)
                                                   : (i_in_data == '0);

endmodule

`default_nettype wire

/* hw/zle_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zle controller
// steers the shared datapath and runs both stream handshakes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module zle_fsm (
   input  wire                  clock,
   input  wire                  reset,
   input  wire                  i_in_valid,
   output logic                 o_in_busy,
   output logic                 o_out_valid,
   input  wire                  i_out_busy,
   input  wire                  i_flag,      // shared flag from datapath
   output logic                 o_load,
   output zle_pkg::sel_out_t    o_sel_out,
   output zle_pkg::sel_cnt_t    o_sel_cnt,
   output zle_pkg::sel_flag_t   o_sel_flag,
   output logic                 o_run_sent
);

   import zle_pkg::*;

   zle_state_t state;
   zle_state_t next_state;

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state <= ST_START;
      end else begin
         state <= next_state;
      end
   end

   // output valid is only raised when the sink is free, so no word waits on it
   always_comb begin
      next_state  = state;
      o_in_busy   = 1'b1;
      o_out_valid = 1'b0;
      o_load      = 1'b0;
      o_sel_out   = SEL_OUT_DATA;
      o_sel_cnt   = SEL_CNT_HOLD;
      o_sel_flag  = SEL_FLAG_ZERO;
      o_run_sent  = 1'b0;
      case (state)
         ST_START: begin
            if (i_in_valid) begin
               o_in_busy  = 1'b0;
               o_load     = 1'b1;
               next_state = i_flag ? ST_START_T : ST_START_E;
            end
         end
         ST_START_T: begin
            o_sel_cnt  = SEL_CNT_START;  // run of one so far
            next_state = ST_ZEROS;
         end
         ST_START_E: begin
            if (!i_out_busy) begin
               o_out_valid = 1'b1;
               next_state  = ST_START;
            end
         end
         ST_ZEROS: begin
            if (i_in_valid) begin
               o_in_busy  = 1'b0;
               o_load     = 1'b1;
               next_state = i_flag ? ST_ZEROS_T : ST_ZEROS_E;
            end
         end
         ST_ZEROS_T: begin
            o_sel_flag = SEL_FLAG_LIMIT;
            next_state = i_flag ? ST_ZEROS_T_T : ST_ZEROS_T_E;
         end
         ST_ZEROS_T_T: begin
            if (!i_out_busy) begin
               o_out_valid = 1'b1;
               o_sel_out   = SEL_OUT_RUN;
               o_sel_cnt   = SEL_CNT_FULL;  // new zero starts the next chunk
               o_run_sent  = 1'b1;
               next_state  = ST_ZEROS;
            end
         end
         ST_ZEROS_T_E: begin
            o_sel_cnt  = SEL_CNT_INC;
            next_state = ST_ZEROS;
         end
         ST_ZEROS_E: begin
            if (!i_out_busy) begin
               o_out_valid = 1'b1;
               o_sel_out   = SEL_OUT_RUN;
               o_run_sent  = 1'b1;
               next_state  = ST_PENDING;
            end
         end
         ST_PENDING: begin
            if (!i_out_busy) begin
               o_out_valid = 1'b1;         // nonzero word that ended the run
               next_state  = ST_START;
            end
         end
         default: begin
            next_state = ST_START;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hw/zle_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zle register block
// APB slave with run limit and run token counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module zle_regs #(
   parameter int CNT_W = zle_pkg::CNT_W_DEF
) (
   input  wire                              clock,
   input  wire                              reset,
   input  wire                              i_psel,
   input  wire                              i_penable,
   input  wire                              i_pwrite,
   input  wire [zle_apb_pkg::APB_AW-1:0]    i_paddr,
   input  wire [zle_apb_pkg::APB_DW-1:0]    i_pwdata,
   input  wire                              i_run_sent,
   output logic [zle_apb_pkg::APB_DW-1:0]   o_prdata,
   output logic                             o_pready,
   output logic [CNT_W-1:0]                 o_limit
);

   import zle_apb_pkg::*;

   logic              wr_en;
   logic [CNT_W-1:0]  wr_limit;
   logic [15:0]       run_count;

   assign wr_en    = i_psel & i_penable & i_pwrite;  // access phase write
   assign wr_limit = i_pwdata[CNT_W-1:0];
   assign o_pready = 1'b1;                           // no wait states

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         o_limit <= LIMIT_RESET[CNT_W-1:0];
      end else if (wr_en && (i_paddr == REG_LIMIT)) begin
         // a limit of zero would never close a run
         o_limit <= (wr_limit == '0) ? CNT_W'(1) : wr_limit;
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         run_count <= '0;
      end else if (wr_en && (i_paddr == REG_RUNS)) begin
         run_count <= '0;                   // any write clears
      end else if (i_run_sent) begin
         run_count <= run_count + 16'd1;    // wraps
      end
   end

   always_comb begin
      o_prdata = '0;
      case (i_paddr)
         REG_LIMIT: o_prdata = {{(APB_DW-CNT_W){1'b0}}, o_limit};
         REG_RUNS:  o_prdata = {{(APB_DW-16){1'b0}}, run_count};
         default:   o_prdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/zle_apb_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zle register package
// APB widths, register map and reset values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package zle_apb_pkg;

   localparam int APB_AW = 8;
   localparam int APB_DW = 32;

   localparam logic [APB_AW-1:0] REG_LIMIT = 8'h00;  // run length limit
   localparam logic [APB_AW-1:0] REG_RUNS  = 8'h04;  // run tokens sent

   // largest count the default 4 bit counter holds
   localparam logic [APB_DW-1:0] LIMIT_RESET = 32'h0000_000f;

endpackage

`default_nettype wire

/* hw/zle_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zle stream package
// default widths, datapath select codes and controller states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package zle_pkg;

   localparam int DATA_W_DEF = 16;  // stream word width
   localparam int CNT_W_DEF  = 4;   // run counter width

   // controller states of the encoder FSM
   typedef enum logic [3:0] {
      ST_START     = 4'd0,
      ST_START_T   = 4'd1,  // first zero seen
      ST_START_E   = 4'd2,  // nonzero word out
      ST_ZEROS     = 4'd3,  // inside a run
      ST_ZEROS_T   = 4'd4,  // limit compare
      ST_ZEROS_T_T = 4'd5,  // full run token out
      ST_ZEROS_T_E = 4'd6,  // count one more zero
      ST_ZEROS_E   = 4'd7,  // closing run token out
      ST_PENDING   = 4'd8   // held nonzero word out
   } zle_state_t;

   typedef enum logic {
      SEL_OUT_DATA = 1'b0,  // held input word
      SEL_OUT_RUN  = 1'b1   // run count
   } sel_out_t;

   typedef enum logic [1:0] {
      SEL_CNT_HOLD  = 2'd0,
      SEL_CNT_START = 2'd1,  // load one, run begins
      SEL_CNT_FULL  = 2'd2,  // load one, after a full token
      SEL_CNT_INC   = 2'd3
   } sel_cnt_t;

   typedef enum logic {
      SEL_FLAG_ZERO  = 1'b0,  // incoming word is zero
      SEL_FLAG_LIMIT = 1'b1   // count has reached the limit
   } sel_flag_t;

endpackage

`default_nettype wire
